/* design/fu_pkg.sv */
package fu_pkg;

    // datapath width of the integer core
    localparam int XLEN = 32;

    // shift amount width follows from the word size
    localparam int SHAMT_W = $clog2(XLEN);

    // tag widths, sized for a 32-entry ROB and 64 physical registers
    localparam int ROBN_W = 5;
    localparam int PRN_W  = 6;

    // multiplier depth used when the top level is not overridden
    localparam int DEF_MULT_STAGES = 4;

    typedef logic        [XLEN-1:0] data_t;    // operand or result word
    typedef logic signed [XLEN-1:0] sdata_t;   // signed view of a word
    typedef logic        [XLEN-1:0] addr_t;    // pc or branch target

    typedef logic [ROBN_W-1:0] robn_t;
    typedef logic [PRN_W-1:0]  prn_t;

    // operands widened by one bit so every mult flavor is a signed multiply
    typedef logic signed [XLEN:0] sext_t;

    // full 33 x 33 product
    typedef logic [2*XLEN+1:0] prod_t;

endpackage

/* design/rv32_pkg.sv */
package rv32_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLT  = 4'h5,
        ALU_SLTU = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_e;

    typedef enum logic [1:0] {
        MULT_MUL    = 2'd0,   // low word
        MULT_MULH   = 2'd1,   // high word, signed x signed
        MULT_MULHSU = 2'd2,   // high word, signed x unsigned
        MULT_MULHU  = 2'd3    // high word, unsigned x unsigned
    } mult_func_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'd0,
        OPA_IS_PC   = 2'd1,
        OPA_IS_ZERO = 2'd2
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'd0,
        OPB_IS_I_IMM = 3'd1,
        OPB_IS_S_IMM = 3'd2,
        OPB_IS_B_IMM = 3'd3,
        OPB_IS_U_IMM = 3'd4,
        OPB_IS_J_IMM = 3'd5
    } opb_sel_e;

    // branch conditions
    localparam funct3_t FUNCT3_BEQ  = 3'b000;
    localparam funct3_t FUNCT3_BNE  = 3'b001;
    localparam funct3_t FUNCT3_BLT  = 3'b100;
    localparam funct3_t FUNCT3_BGE  = 3'b101;
    localparam funct3_t FUNCT3_BLTU = 3'b110;
    localparam funct3_t FUNCT3_BGEU = 3'b111;

    // instruction field positions
    localparam int FUNCT3_MSB   = 14;
    localparam int FUNCT3_LSB   = 12;
    localparam int INST_SIGN    = 31;
    localparam int I_IMM_MSB    = 31;
    localparam int I_IMM_LSB    = 20;
    localparam int S_IMM_HI_MSB = 31;
    localparam int S_IMM_HI_LSB = 25;
    localparam int S_IMM_LO_MSB = 11;
    localparam int S_IMM_LO_LSB = 7;
    localparam int B_IMM_BIT11  = 7;
    localparam int B_IMM_HI_MSB = 30;
    localparam int B_IMM_HI_LSB = 25;
    localparam int B_IMM_LO_MSB = 11;
    localparam int B_IMM_LO_LSB = 8;
    localparam int U_IMM_MSB    = 31;
    localparam int U_IMM_LSB    = 12;
    localparam int J_IMM_HI_MSB = 19;
    localparam int J_IMM_HI_LSB = 12;
    localparam int J_IMM_BIT11  = 20;
    localparam int J_IMM_LO_MSB = 30;
    localparam int J_IMM_LO_LSB = 21;

endpackage

/* design/fu_if.sv */
`timescale 1ns/1ns

// operands and tags heading into a functional unit
interface fu_issue_if;
    import fu_pkg::*;

    logic  valid;
    data_t a;       // operand a after the mux
    data_t b;       // operand b after the mux
    robn_t robn;
    prn_t  prn;

    modport issue (
        output valid, a, b, robn, prn
    );

    modport exec (
        input valid, a, b, robn, prn
    );

endinterface

// finished result with its tags
interface fu_result_if;
    import fu_pkg::*;

    logic  done;
    data_t result;
    robn_t robn;
    prn_t  prn;

    modport source (
        output done, result, robn, prn
    );

    modport sink (
        input done, result, robn, prn
    );

endinterface

/* design/operand_select.sv */
`timescale 1ns/1ns

module operand_select (
    input  logic               valid,
    input  rv32_pkg::inst_t    inst,
    input  fu_pkg::addr_t      pc,
    input  fu_pkg::data_t      rs1,
    input  fu_pkg::data_t      rs2,
    input  rv32_pkg::opa_sel_e opa_sel,
    input  rv32_pkg::opb_sel_e opb_sel,
    input  fu_pkg::robn_t      robn,
    input  fu_pkg::prn_t       prn,
    fu_issue_if.issue          issue
);
    import fu_pkg::*;
    import rv32_pkg::*;

    data_t i_imm, s_imm, b_imm, u_imm, j_imm;

    // sign-extended immediates, one per format
    assign i_imm = {{20{inst[INST_SIGN]}}, inst[I_IMM_MSB:I_IMM_LSB]};
    assign s_imm = {{20{inst[INST_SIGN]}}, inst[S_IMM_HI_MSB:S_IMM_HI_LSB],
                    inst[S_IMM_LO_MSB:S_IMM_LO_LSB]};
    assign b_imm = {{19{inst[INST_SIGN]}}, inst[INST_SIGN], inst[B_IMM_BIT11],
                    inst[B_IMM_HI_MSB:B_IMM_HI_LSB], inst[B_IMM_LO_MSB:B_IMM_LO_LSB], 1'b0};
    assign u_imm = {inst[U_IMM_MSB:U_IMM_LSB], 12'b0};   // upper 20, low bits zero
    assign j_imm = {{11{inst[INST_SIGN]}}, inst[INST_SIGN], inst[J_IMM_HI_MSB:J_IMM_HI_LSB],
                    inst[J_IMM_BIT11], inst[J_IMM_LO_MSB:J_IMM_LO_LSB], 1'b0};

    always_comb begin
        case (opa_sel)
            OPA_IS_RS1:  issue.a = rs1;
            OPA_IS_PC:   issue.a = pc;   // auipc, jal link
            OPA_IS_ZERO: issue.a = '0;   // lui
            default:     issue.a = '0;
        endcase
    end

    always_comb begin
        case (opb_sel)
            OPB_IS_RS2:   issue.b = rs2;
            OPB_IS_I_IMM: issue.b = i_imm;
            OPB_IS_S_IMM: issue.b = s_imm;
            OPB_IS_B_IMM: issue.b = b_imm;
            OPB_IS_U_IMM: issue.b = u_imm;
            OPB_IS_J_IMM: issue.b = j_imm;
            default:      issue.b = '0;
        endcase
    end

    assign issue.valid = valid;
    assign issue.robn  = robn;
    assign issue.prn   = prn;

endmodule

/* design/alu_core.sv */
`timescale 1ns/1ns

// single-cycle integer alu, purely combinational
module alu_core (
    fu_issue_if.exec           op,
    input rv32_pkg::alu_func_e func,
    fu_result_if.source        res
);
    import fu_pkg::*;
    import rv32_pkg::*;

    sdata_t             a_s;
    sdata_t             b_s;
    logic [SHAMT_W-1:0] shamt;
    data_t              result;

    assign a_s   = op.a;
    assign b_s   = op.b;
    assign shamt = op.b[SHAMT_W-1:0];   // rv32 uses only the low 5 bits

    always_comb begin
        case (func)
            ALU_ADD:  result = op.a + op.b;
            ALU_SUB:  result = op.a - op.b;
            ALU_AND:  result = op.a & op.b;
            ALU_OR:   result = op.a | op.b;
            ALU_XOR:  result = op.a ^ op.b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, a_s < b_s};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, op.a < op.b};
            ALU_SLL:  result = op.a << shamt;
            ALU_SRL:  result = op.a >> shamt;
            ALU_SRA:  result = a_s >>> shamt;   // fills with the sign bit
            default:  result = '0;
        endcase
    end

    // no back-pressure, result leaves in the issue cycle
    assign res.done   = op.valid;
    assign res.result = result;
    assign res.robn   = op.robn;
    assign res.prn    = op.prn;

endmodule

/* design/mult_pipe.sv */
`timescale 1ns/1ns

module mult_pipe #(
    parameter int NUM_MULT_STAGES = fu_pkg::DEF_MULT_STAGES
) (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 squash,
    input  logic                 avail,
    input  rv32_pkg::mult_func_e func,
    fu_issue_if.exec             op,
    fu_result_if.source          res
);
    import fu_pkg::*;
    import rv32_pkg::*;

    localparam int LAST = NUM_MULT_STAGES - 1;

    logic                 sign_a, sign_b;
    sext_t                ext_a, ext_b;
    logic signed [2*XLEN+1:0] product;

    // per-stage state
    logic [NUM_MULT_STAGES-1:0] stg_valid;
    prod_t      stg_prod [NUM_MULT_STAGES];
    mult_func_e stg_func [NUM_MULT_STAGES];
    robn_t      stg_robn [NUM_MULT_STAGES];
    prn_t       stg_prn  [NUM_MULT_STAGES];

    // widen to 33 bits so one signed multiply covers all four flavors
    assign sign_a = (func == MULT_MULH) || (func == MULT_MULHSU);
    assign sign_b = (func == MULT_MULH);
    assign ext_a  = {sign_a & op.a[XLEN-1], op.a};
    assign ext_b  = {sign_b & op.b[XLEN-1], op.b};
    assign product = (2*XLEN+2)'(ext_a) * (2*XLEN+2)'(ext_b);   // full 66-bit product

    // reset or squash clears the valid bits even while stalled
    always_ff @(posedge clock) begin
        if (rst || squash) begin
            stg_valid <= '0;
        end else if (avail) begin
            stg_valid <= {stg_valid[NUM_MULT_STAGES-2:0], op.valid};
        end
    end

    // payload shifts only when the consumer takes the last stage
    always_ff @(posedge clock) begin
        if (avail) begin
            stg_prod[0] <= product;
            stg_func[0] <= func;
            stg_robn[0] <= op.robn;
            stg_prn[0]  <= op.prn;
            for (int i = 1; i < NUM_MULT_STAGES; i++) begin
                stg_prod[i] <= stg_prod[i-1];
                stg_func[i] <= stg_func[i-1];
                stg_robn[i] <= stg_robn[i-1];
                stg_prn[i]  <= stg_prn[i-1];
            end
        end
    end

    // word select at the output
    assign res.done   = stg_valid[LAST];
    assign res.result = (stg_func[LAST] == MULT_MUL) ? stg_prod[LAST][XLEN-1:0]
                                                     : stg_prod[LAST][2*XLEN-1:XLEN];
    assign res.robn   = stg_robn[LAST];
    assign res.prn    = stg_prn[LAST];

endmodule

/* design/branch_resolve.sv */
`timescale 1ns/1ns

module branch_resolve (
    fu_result_if.sink        alu,
    input  rv32_pkg::funct3_t funct3,
    input  fu_pkg::data_t     rs1,
    input  fu_pkg::data_t     rs2,
    input  logic              cond_branch,
    input  logic              uncond_branch,
    output logic              executed,
    output logic              taken,
    output fu_pkg::addr_t     target
);
    import fu_pkg::*;
    import rv32_pkg::*;

    sdata_t rs1_s;
    sdata_t rs2_s;
    logic   cond_true;

    // compare uses the register values, not the muxed operands
    assign rs1_s = rs1;
    assign rs2_s = rs2;

    always_comb begin
        case (funct3)
            FUNCT3_BEQ:  cond_true = (rs1 == rs2);
            FUNCT3_BNE:  cond_true = (rs1 != rs2);
            FUNCT3_BLT:  cond_true = (rs1_s < rs2_s);
            FUNCT3_BGE:  cond_true = (rs1_s >= rs2_s);
            FUNCT3_BLTU: cond_true = (rs1 < rs2);
            FUNCT3_BGEU: cond_true = (rs1 >= rs2);
            default:     cond_true = 1'b0;   // 010, 011 are not branches
        endcase
    end

    // jal/jalr always redirect
    assign taken = uncond_branch || (cond_branch && cond_true);

    // rob only needs a report for conditional branches
    assign executed = alu.done && cond_branch;

    // pc + imm computed by the alu
    assign target = alu.result;

endmodule

/* design/fu_top.sv */
`timescale 1ns/1ns

module fu_top #(
    parameter int NUM_MULT_STAGES = fu_pkg::DEF_MULT_STAGES
) (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 squash,

    // alu lane issue
    input  logic                 alu_valid,
    input  rv32_pkg::inst_t      alu_inst,
    input  fu_pkg::addr_t        alu_pc,
    input  fu_pkg::data_t        alu_rs1,
    input  fu_pkg::data_t        alu_rs2,
    input  rv32_pkg::alu_func_e  alu_func,
    input  rv32_pkg::opa_sel_e   alu_opa_sel,
    input  rv32_pkg::opb_sel_e   alu_opb_sel,
    input  logic                 alu_cond_branch,
    input  logic                 alu_uncond_branch,
    input  fu_pkg::robn_t        alu_robn,
    input  fu_pkg::prn_t         alu_prn,

    // multiplier lane issue
    input  logic                 mult_valid,
    input  rv32_pkg::inst_t      mult_inst,
    input  fu_pkg::addr_t        mult_pc,
    input  fu_pkg::data_t        mult_rs1,
    input  fu_pkg::data_t        mult_rs2,
    input  rv32_pkg::mult_func_e mult_func,
    input  rv32_pkg::opa_sel_e   mult_opa_sel,
    input  rv32_pkg::opb_sel_e   mult_opb_sel,
    input  fu_pkg::robn_t        mult_robn,
    input  fu_pkg::prn_t         mult_prn,
    input  logic                 mult_avail,   // result taken, pipe may advance

    // alu lane results
    output logic                 alu_done,
    output fu_pkg::data_t        alu_result,
    output fu_pkg::robn_t        alu_out_robn,
    output fu_pkg::prn_t         alu_out_prn,
    output logic                 branch_executed,
    output logic                 branch_taken,
    output fu_pkg::addr_t        branch_target,

    // multiplier lane results
    output logic                 mult_done,
    output fu_pkg::data_t        mult_result,
    output fu_pkg::robn_t        mult_out_robn,
    output fu_pkg::prn_t         mult_out_prn
);
    import rv32_pkg::*;

    funct3_t alu_funct3;

    fu_issue_if  alu_issue ();
    fu_issue_if  mult_issue ();
    fu_result_if alu_res ();
    fu_result_if mult_res ();

    assign alu_funct3 = alu_inst[FUNCT3_MSB:FUNCT3_LSB];

    operand_select u_alu_opsel (
        .valid   (alu_valid),
        .inst    (alu_inst),
        .pc      (alu_pc),
        .rs1     (alu_rs1),
        .rs2     (alu_rs2),
        .opa_sel (alu_opa_sel),
        .opb_sel (alu_opb_sel),
        .robn    (alu_robn),
        .prn     (alu_prn),
        .issue   (alu_issue)
    );

    operand_select u_mult_opsel (
        .valid   (mult_valid),
        .inst    (mult_inst),
        .pc      (mult_pc),
        .rs1     (mult_rs1),
        .rs2     (mult_rs2),
        .opa_sel (mult_opa_sel),
        .opb_sel (mult_opb_sel),
        .robn    (mult_robn),
        .prn     (mult_prn),
        .issue   (mult_issue)
    );

    alu_core u_alu (
        .op   (alu_issue),
        .func (alu_func),
        .res  (alu_res)
    );

    mult_pipe #(
        .NUM_MULT_STAGES (NUM_MULT_STAGES)
    ) u_mult (
        .clock  (clock),
        .rst    (rst),
        .squash (squash),
        .avail  (mult_avail),
        .func   (mult_func),
        .op     (mult_issue),
        .res    (mult_res)
    );

    branch_resolve u_branch (
        .alu           (alu_res),
        .funct3        (alu_funct3),
        .rs1           (alu_rs1),
        .rs2           (alu_rs2),
        .cond_branch   (alu_cond_branch),
        .uncond_branch (alu_uncond_branch),
        .executed      (branch_executed),
        .taken         (branch_taken),
        .target        (branch_target)
    );

    assign alu_done      = alu_res.done;
    assign alu_result    = alu_res.result;
    assign alu_out_robn  = alu_res.robn;
    assign alu_out_prn   = alu_res.prn;

    assign mult_done     = mult_res.done;
    assign mult_result   = mult_res.result;
    assign mult_out_robn = mult_res.robn;
    assign mult_out_prn  = mult_res.prn;

endmodule

/* tb/fu_checker.sv */
`timescale 1ns/1ns

module fu_checker #(
    parameter int NUM_MULT_STAGES = fu_pkg::DEF_MULT_STAGES
) (
    input  logic                 clock, rst, squash,
    input  logic                 alu_valid, alu_cond_branch, alu_uncond_branch,
    input  rv32_pkg::inst_t      alu_inst, mult_inst,
    input  fu_pkg::addr_t        alu_pc, mult_pc, branch_target,
    input  fu_pkg::data_t        alu_rs1, alu_rs2, mult_rs1, mult_rs2,
    input  fu_pkg::data_t        alu_result, mult_result,
    input  rv32_pkg::alu_func_e  alu_func,
    input  rv32_pkg::mult_func_e mult_func,
    input  rv32_pkg::opa_sel_e   alu_opa_sel, mult_opa_sel,
    input  rv32_pkg::opb_sel_e   alu_opb_sel, mult_opb_sel,
    input  fu_pkg::robn_t        alu_robn, mult_robn, alu_out_robn, mult_out_robn,
    input  fu_pkg::prn_t         alu_prn, mult_prn, alu_out_prn, mult_out_prn,
    input  logic                 mult_valid, mult_avail, alu_done, mult_done,
    input  logic                 branch_executed, branch_taken,
    output int                   errors, checks, pending
);
    import fu_pkg::*;
    import rv32_pkg::*;

    data_t       exp_q[$];   // expected mult results, issue order
    logic [10:0] tag_q[$];   // {robn, prn}
    int          adv_q[$];   // advance count at issue
    int          adv = 0;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          pend = 0;
    logic        after_rst = 1'b0;
    logic        held = 1'b0;
    data_t       held_result;
    logic [10:0] held_tag;
    data_t       alu_exp;

    assign errors  = err_cnt;
    assign checks  = chk_cnt;
    assign pending = pend;

    function automatic data_t opa_model(opa_sel_e s, addr_t pc, data_t rs1);
        case (s)
            OPA_IS_RS1: return rs1;
            OPA_IS_PC:  return pc;
            default:    return '0;
        endcase
    endfunction

    // rv32 immediate formats, bit for bit
    function automatic data_t opb_model(inst_t i, opb_sel_e s, data_t rs2);
        case (s)
            OPB_IS_RS2:   return rs2;
            OPB_IS_I_IMM: return {{21{i[31]}}, i[30:20]};
            OPB_IS_S_IMM: return {{21{i[31]}}, i[30:25], i[11:7]};
            OPB_IS_B_IMM: return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            OPB_IS_U_IMM: return {i[31:12], 12'h000};
            OPB_IS_J_IMM: return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            default:      return '0;
        endcase
    endfunction

    function automatic data_t alu_model(alu_func_e f, data_t a, data_t b);
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            default:  return '0;
        endcase
    endfunction

    function automatic logic cond_model(logic [2:0] f3, data_t x, data_t y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            3'b111:  return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    // 64-bit product of extended operands, low 64 bits are exact
    function automatic data_t mult_model(mult_func_e f, data_t a, data_t b);
        logic        sa;
        logic        sb;
        logic [63:0] p;
        sa = (f == MULT_MULH) || (f == MULT_MULHSU);
        sb = (f == MULT_MULH);
        p  = {{32{a[31] & sa}}, a} * {{32{b[31] & sb}}, b};
        return (f == MULT_MUL) ? p[31:0] : p[63:32];
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clock) begin
        if (rst) begin
            exp_q.delete();
            tag_q.delete();
            adv_q.delete();
            after_rst = 1'b1;
            held = 1'b0;
        end else begin
            expect_eq("alu_done", 32'(alu_done), 32'(alu_valid));
            expect_eq("branch_executed", 32'(branch_executed),
                      32'(alu_valid && alu_cond_branch));
            if (alu_valid) begin
                alu_exp = alu_model(alu_func, opa_model(alu_opa_sel, alu_pc, alu_rs1),
                                    opb_model(alu_inst, alu_opb_sel, alu_rs2));
                expect_eq("alu_result", alu_result, alu_exp);
                expect_eq("alu tags", 32'({alu_out_robn, alu_out_prn}),
                          32'({alu_robn, alu_prn}));
                expect_eq("branch_target", branch_target, alu_exp);
                expect_eq("branch_taken", 32'(branch_taken),
                          32'(alu_uncond_branch || (alu_cond_branch &&
                              cond_model(alu_inst[14:12], alu_rs1, alu_rs2))));
            end
            if (after_rst)
                expect_eq("mult_done after reset", 32'(mult_done), 32'd0);
            after_rst = 1'b0;
            if (held) begin   // stalled output must not move
                expect_eq("stalled mult_done", 32'(mult_done), 32'd1);
                expect_eq("stalled mult_result", mult_result, held_result);
                expect_eq("stalled mult tags", 32'({mult_out_robn, mult_out_prn}),
                          32'(held_tag));
            end
            if (mult_done && mult_avail) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("mult result for robn %0d came out at %0t ns with nothing pending",
                             mult_out_robn, $time);
                end else begin
                    expect_eq("mult_result", mult_result, exp_q.pop_front());
                    expect_eq("mult tags", 32'({mult_out_robn, mult_out_prn}),
                              32'(tag_q.pop_front()));
                    expect_eq("mult latency", 32'(adv - adv_q.pop_front()),
                              32'(NUM_MULT_STAGES));
                end
            end
            if (squash) begin   // everything in flight is dropped, incoming issue too
                exp_q.delete();
                tag_q.delete();
                adv_q.delete();
            end else if (mult_valid && mult_avail) begin
                exp_q.push_back(mult_model(mult_func,
                                           opa_model(mult_opa_sel, mult_pc, mult_rs1),
                                           opb_model(mult_inst, mult_opb_sel, mult_rs2)));
                tag_q.push_back({mult_robn, mult_prn});
                adv_q.push_back(adv);
            end
            held        = mult_done && !mult_avail && !squash;
            held_result = mult_result;
            held_tag    = {mult_out_robn, mult_out_prn};
            if (mult_avail)
                adv++;
        end
        pend = exp_q.size();
    end

endmodule

/* tb/fu_tb.sv */
`timescale 1ns/1ns

module fu_tb;
    import fu_pkg::*;
    import rv32_pkg::*;

    localparam int NUM_MULT_STAGES = DEF_MULT_STAGES;
    localparam int N_ALU     = 300;
    localparam int N_MULT    = 200;
    localparam int N_SQ      = 40;
    localparam int TOTAL_OPS = 3 * N_ALU + 2 * N_MULT + 3 * N_SQ;

    logic       clock, rst, squash;
    logic       alu_valid, alu_cond_branch, alu_uncond_branch;
    inst_t      alu_inst, mult_inst;
    addr_t      alu_pc, mult_pc, branch_target;
    data_t      alu_rs1, alu_rs2, mult_rs1, mult_rs2, alu_result, mult_result;
    alu_func_e  alu_func;
    mult_func_e mult_func;
    opa_sel_e   alu_opa_sel, mult_opa_sel;
    opb_sel_e   alu_opb_sel, mult_opb_sel;
    robn_t      alu_robn, mult_robn, alu_out_robn, mult_out_robn;
    prn_t       alu_prn, mult_prn, alu_out_prn, mult_out_prn;
    logic       mult_valid, mult_avail, alu_done, mult_done, branch_executed, branch_taken;
    int         errors, checks, pending;
    int         seed;
    int         drain_fail = 0;
    int         last_errors = 0;
    int         last_checks = 0;

    fu_top #(.NUM_MULT_STAGES(NUM_MULT_STAGES)) u_dut (.*);

    fu_checker #(.NUM_MULT_STAGES(NUM_MULT_STAGES)) u_chk (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic idle_inputs();
        squash = 1'b0;
        alu_valid = 1'b0;
        alu_inst = '0;
        alu_pc = '0;
        alu_rs1 = '0;
        alu_rs2 = '0;
        alu_func = ALU_ADD;
        alu_opa_sel = OPA_IS_RS1;
        alu_opb_sel = OPB_IS_RS2;
        alu_cond_branch = 1'b0;
        alu_uncond_branch = 1'b0;
        alu_robn = '0;
        alu_prn = '0;
        mult_valid = 1'b0;
        mult_inst = '0;
        mult_pc = '0;
        mult_rs1 = '0;
        mult_rs2 = '0;
        mult_func = MULT_MUL;
        mult_opa_sel = OPA_IS_RS1;
        mult_opb_sel = OPB_IS_RS2;
        mult_robn = '0;
        mult_prn = '0;
        mult_avail = 1'b1;
    endtask

    // mode 0 register operands, 1 random selects, 2 branches
    task automatic drive_alu(input int mode);
        @(negedge clock);
        alu_valid = (pick(4) != 0);
        alu_inst = $random(seed);
        alu_pc = $random(seed);
        alu_rs1 = $random(seed);
        alu_rs2 = (pick(4) == 0) ? alu_rs1 : $random(seed);   // hit beq/bge now and then
        alu_robn = robn_t'($random(seed));
        alu_prn = prn_t'($random(seed));
        alu_func = alu_func_e'(pick(10));
        alu_opa_sel = OPA_IS_RS1;
        alu_opb_sel = OPB_IS_RS2;
        alu_cond_branch = 1'b0;
        alu_uncond_branch = 1'b0;
        if (mode == 1) begin
            alu_opa_sel = opa_sel_e'(pick(3));
            alu_opb_sel = opb_sel_e'(pick(6));
        end else if (mode == 2) begin   // target is pc + b immediate
            alu_func = ALU_ADD;
            alu_opa_sel = OPA_IS_PC;
            alu_opb_sel = OPB_IS_B_IMM;
            alu_cond_branch = (pick(2) == 0);
            alu_uncond_branch = !alu_cond_branch && (pick(3) == 0);
        end
    endtask

    task automatic drive_mult(input bit stall);
        @(negedge clock);
        mult_avail = stall ? (pick(3) != 0) : 1'b1;
        mult_valid = mult_avail && (pick(4) != 0);   // never into a stalled pipe
        mult_inst = $random(seed);
        mult_pc = $random(seed);
        mult_rs1 = $random(seed);
        mult_rs2 = $random(seed);
        mult_robn = robn_t'($random(seed));
        mult_prn = prn_t'($random(seed));
        mult_func = mult_func_e'(pick(4));
        mult_opa_sel = (pick(4) == 0) ? opa_sel_e'(pick(3)) : OPA_IS_RS1;
        mult_opb_sel = (pick(4) == 0) ? opb_sel_e'(pick(6)) : OPB_IS_RS2;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clock);
        mult_valid = 1'b0;
        mult_avail = 1'b1;
        while (pending != 0 && waited < 4 * NUM_MULT_STAGES + 20) begin
            @(negedge clock);
            waited++;
        end
        if (pending != 0) begin
            drain_fail++;
            $display("multiplier never returned %0d pending results, gave up at %0t ns",
                     pending, $time);
        end
    endtask

    task automatic end_test(input string name);
        @(negedge clock);
        alu_valid = 1'b0;
        $display("%s: %0d checks, %0d errors", name, checks - last_checks,
                 errors - last_errors);
        last_checks = checks;
        last_errors = errors;
    endtask

    initial begin
        repeat (TOTAL_OPS * (NUM_MULT_STAGES + 4) + 200) @(posedge clock);
        $display("watchdog expired, the run did not finish in time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        seed = 32'h8f1b_599d;
        rst = 1'b1;
        idle_inputs();
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        repeat (N_ALU) drive_alu(0);
        end_test("test 1 alu register operands");
        repeat (N_ALU) drive_alu(1);
        end_test("test 2 operand selection");
        repeat (N_ALU) drive_alu(2);
        end_test("test 3 branches");

        repeat (N_MULT) drive_mult(1'b0);
        drain();
        end_test("test 4 multiplier values and latency");
        repeat (N_MULT) drive_mult(1'b1);
        drain();
        end_test("test 5 multiplier back-pressure");

        repeat (N_SQ) drive_mult(1'b0);
        @(negedge clock);
        mult_valid = 1'b0;
        mult_avail = 1'b1;
        rst = 1'b1;   // drops whatever is in flight
        repeat (2) @(negedge clock);
        rst = 1'b0;
        repeat (N_SQ) drive_mult(1'b1);
        @(negedge clock);
        mult_valid = 1'b0;
        mult_avail = 1'b1;
        squash = 1'b1;
        @(negedge clock);
        squash = 1'b0;
        repeat (N_SQ) drive_mult(1'b0);
        drain();
        end_test("test 6 reset and squash");

        $display("summary: 6 tests, %0d checks, %0d errors, %0d drain failures",
                 checks, errors, drain_fail);
        if (errors == 0 && drain_fail == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/fu_pkg.sv
design/rv32_pkg.sv
design/fu_if.sv
design/operand_select.sv
design/alu_core.sv
design/mult_pipe.sv
design/branch_resolve.sv
design/fu_top.sv
tb/fu_checker.sv
tb/fu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the execution stage testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module fu_tb -f verilog.f -o fu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
